/* flist.f */
+incdir+tb
source/friet_pkg.sv
source/stream_buffer_in.sv
source/stream_buffer_out.sv
source/duplex_core.sv
source/stream_controller.sv
source/tag_verify.sv
source/friet_stream_top.sv
tb/friet_stream_tb.sv

/* source/duplex_core.sv */
//--------------------------------------------------------------------------
// Duplex core: 128-bit state, load, encrypt, decrypt and squeeze, with
// a one-lane left rotation of the state after each data block
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module duplex_core (
    input  wire                        clk,
    input  wire                        reg_compare_tag_rst,
    input  wire friet_pkg::core_oper_t core_oper,
    input  wire                        core_start,
    input  wire                        verify_mode,
    input  wire friet_pkg::block_t     in_block,
    input  wire                        in_block_last,
    input  wire                        in_block_valid,
    output logic                       in_block_ready,
    output friet_pkg::block_t          out_block,
    output logic                       out_block_last,
    output logic                       out_block_valid,
    input  wire                        out_block_ready
);

    localparam int bw = friet_pkg::block_width;
    localparam int lw = friet_pkg::lane_width;

    friet_pkg::block_t state;
    friet_pkg::block_t mixed;
    logic slot_valid;
    logic take;

    // Block step in place of the permutation rounds
    function automatic friet_pkg::block_t rotl_lane(input friet_pkg::block_t x);
        return {x[bw-lw-1:0], x[bw-1:bw-lw]};
    endfunction

    // Verify pairs the squeezed state with the tag block, not buffer out
    always_comb begin
        if (verify_mode) begin
            in_block_ready = slot_valid;
        end else if (core_oper == friet_pkg::core_squeeze) begin
            in_block_ready = 1'b0;
        end else begin
            in_block_ready = ~slot_valid | out_block_ready;
        end
    end

    assign take = in_block_valid & in_block_ready;
    assign mixed = state ^ in_block;
    assign out_block_valid = slot_valid & ~verify_mode;

    always_ff @(posedge clk) begin
        if (reg_compare_tag_rst) begin
            state <= '0;
        end else if (take && !verify_mode) begin
            case (core_oper)
                friet_pkg::core_load:    state <= in_block;
                friet_pkg::core_encrypt: state <= rotl_lane(mixed);
                friet_pkg::core_decrypt: state <= rotl_lane(in_block);
                default:                 state <= state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reg_compare_tag_rst) begin
            slot_valid <= 1'b0;
            out_block_last <= 1'b0;
        end else if (core_start) begin
            slot_valid <= 1'b1;
            out_block_last <= 1'b1;
        end else if (take && verify_mode) begin
            slot_valid <= 1'b0;
        end else if (take && core_oper != friet_pkg::core_load) begin
            slot_valid <= 1'b1;
            out_block_last <= in_block_last;
        end else if (out_block_valid && out_block_ready) begin
            slot_valid <= 1'b0;
        end
    end

    // Squeeze exposes the state, data blocks the state xor input
    always_ff @(posedge clk) begin
        if (core_start) begin
            out_block <= state;
        end else if (take) begin
            out_block <= mixed;
        end
    end

endmodule

`default_nettype wire

/* source/friet_pkg.sv */
//--------------------------------------------------------------------------
// Shared definitions of the authenticated stream engine: block and lane
// widths, the block type, instruction codes, core operation codes and
// the fixed marker bits of the verdict word
//--------------------------------------------------------------------------
`default_nettype none

package friet_pkg;

    // Cipher block and duplex state
    parameter int block_width = 128;
    parameter int lane_width = 32;

    typedef logic [block_width-1:0] block_t;

    // Codes on the instruction bus
    typedef enum logic [3:0] {
        inst_load_key = 4'd1,
        inst_encrypt  = 4'd2,
        inst_decrypt  = 4'd3,
        inst_tag      = 4'd4,
        inst_verify   = 4'd5
    } inst_t;

    // Operation applied by the duplex core to each block
    typedef enum logic [1:0] {
        core_load    = 2'd0,
        core_encrypt = 2'd1,
        core_decrypt = 2'd2,
        core_squeeze = 2'd3
    } core_oper_t;

    // Bits 3..1 of the verdict word
    parameter logic [2:0] verdict_fixed_bits = 3'b111;

endpackage

`default_nettype wire

/* source/friet_stream_top.sv */
//--------------------------------------------------------------------------
// Top level of the authenticated stream engine: controller, input and
// output buffers, duplex core and tag verification
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module friet_stream_top #(
    parameter int DIN_DOUT_WIDTH = 32
) (
    input  wire                        clk,
    input  wire                        reg_compare_tag_rst,
    input  wire friet_pkg::inst_t      inst,
    input  wire                        inst_valid,
    output logic                       inst_ready,
    input  wire [DIN_DOUT_WIDTH-1:0]   din,
    input  wire                        din_last,
    input  wire                        din_valid,
    output logic                       din_ready,
    output logic [DIN_DOUT_WIDTH-1:0]  dout,
    output logic                       dout_last,
    output logic                       dout_valid,
    input  wire                        dout_ready
);

    logic in_enable;
    logic din_ready_int;

    friet_pkg::block_t in_block;
    logic in_block_last;
    logic in_block_valid;
    logic in_block_ready;

    friet_pkg::block_t out_block;
    logic out_block_last;
    logic out_block_valid;
    logic out_block_ready;

    logic [DIN_DOUT_WIDTH-1:0] buf_dout;
    logic buf_dout_last;
    logic buf_dout_valid;
    logic buf_dout_ready;

    friet_pkg::core_oper_t core_oper;
    logic core_start;
    logic verify_mode;
    logic clear_compare;
    logic verdict_select;

    stream_controller #(.DIN_DOUT_WIDTH(DIN_DOUT_WIDTH)) controller (
        .clk(clk), .reg_compare_tag_rst(reg_compare_tag_rst),
        .inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready),
        .din_valid(din_valid), .din_ready_int(din_ready_int),
        .din_ready(din_ready), .in_enable(in_enable),
        .in_block_valid(in_block_valid), .in_block_ready(in_block_ready),
        .in_block_last(in_block_last),
        .core_oper(core_oper), .core_start(core_start),
        .verify_mode(verify_mode), .clear_compare(clear_compare),
        .verdict_select(verdict_select),
        .dout_valid(dout_valid), .dout_ready(dout_ready), .dout_last(dout_last)
    );

    // Buffer sees valid words only while the controller opens the input
    stream_buffer_in #(.DIN_DOUT_WIDTH(DIN_DOUT_WIDTH)) buffer_in (
        .clk(clk), .reg_compare_tag_rst(reg_compare_tag_rst),
        .din(din), .din_last(din_last), .din_valid(in_enable),
        .din_ready(din_ready_int),
        .in_block(in_block), .in_block_last(in_block_last),
        .in_block_valid(in_block_valid), .in_block_ready(in_block_ready)
    );

    duplex_core core (
        .clk(clk), .reg_compare_tag_rst(reg_compare_tag_rst),
        .core_oper(core_oper), .core_start(core_start), .verify_mode(verify_mode),
        .in_block(in_block), .in_block_last(in_block_last),
        .in_block_valid(in_block_valid), .in_block_ready(in_block_ready),
        .out_block(out_block), .out_block_last(out_block_last),
        .out_block_valid(out_block_valid), .out_block_ready(out_block_ready)
    );

    stream_buffer_out #(.DIN_DOUT_WIDTH(DIN_DOUT_WIDTH)) buffer_out (
        .clk(clk), .reg_compare_tag_rst(reg_compare_tag_rst),
        .out_block(out_block), .out_block_last(out_block_last),
        .out_block_valid(out_block_valid), .out_block_ready(out_block_ready),
        .buf_dout(buf_dout), .buf_dout_last(buf_dout_last),
        .buf_dout_valid(buf_dout_valid), .buf_dout_ready(buf_dout_ready)
    );

    // Under verify the core is ready exactly while its squeezed state waits
    tag_verify #(.DIN_DOUT_WIDTH(DIN_DOUT_WIDTH)) verify (
        .clk(clk), .reg_compare_tag_rst(reg_compare_tag_rst),
        .clear_compare(clear_compare), .verify_mode(verify_mode),
        .verdict_select(verdict_select),
        .out_block(out_block), .out_block_valid(in_block_ready),
        .in_block(in_block), .in_block_valid(in_block_valid),
        .buf_dout(buf_dout), .buf_dout_last(buf_dout_last),
        .buf_dout_valid(buf_dout_valid), .buf_dout_ready(buf_dout_ready),
        .dout(dout), .dout_last(dout_last), .dout_valid(dout_valid),
        .dout_ready(dout_ready)
    );

endmodule

`default_nettype wire

/* source/stream_buffer_in.sv */
//--------------------------------------------------------------------------
// Input buffer packing din words into 128-bit blocks, most significant
// word first, with the last flag of the final word
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stream_buffer_in #(
    parameter int DIN_DOUT_WIDTH = 32
) (
    input  wire                       clk,
    input  wire                       reg_compare_tag_rst,
    input  wire [DIN_DOUT_WIDTH-1:0]  din,
    input  wire                       din_last,
    input  wire                       din_valid,
    output logic                      din_ready,
    output friet_pkg::block_t         in_block,
    output logic                      in_block_last,
    output logic                      in_block_valid,
    input  wire                       in_block_ready
);

    localparam int words = friet_pkg::block_width / DIN_DOUT_WIDTH;
    localparam int cnt_width = $clog2(words);

    logic [cnt_width-1:0] cnt;
    logic din_xfer;
    logic final_word;

    // One block of storage, so no words while it waits
    assign din_ready = ~in_block_valid;
    assign din_xfer = din_valid & din_ready;
    assign final_word = (cnt == cnt_width'(words - 1));

    always_ff @(posedge clk) begin
        if (reg_compare_tag_rst) begin
            cnt <= '0;
            in_block_valid <= 1'b0;
            in_block_last <= 1'b0;
        end else if (din_xfer) begin
            if (final_word) begin
                cnt <= '0;
                in_block_valid <= 1'b1;
                in_block_last <= din_last;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (in_block_valid && in_block_ready) begin
            in_block_valid <= 1'b0;
        end
    end

    // Earlier words move toward the top
    always_ff @(posedge clk) begin
        if (din_xfer) begin
            in_block <= {in_block[friet_pkg::block_width-DIN_DOUT_WIDTH-1:0], din};
        end
    end

endmodule

`default_nettype wire

/* source/stream_buffer_out.sv */
//--------------------------------------------------------------------------
// Output buffer unpacking 128-bit blocks into words, most significant
// word first, last set on the final word of a last block
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stream_buffer_out #(
    parameter int DIN_DOUT_WIDTH = 32
) (
    input  wire                       clk,
    input  wire                       reg_compare_tag_rst,
    input  wire friet_pkg::block_t    out_block,
    input  wire                       out_block_last,
    input  wire                       out_block_valid,
    output logic                      out_block_ready,
    output logic [DIN_DOUT_WIDTH-1:0] buf_dout,
    output logic                      buf_dout_last,
    output logic                      buf_dout_valid,
    input  wire                       buf_dout_ready
);

    localparam int words = friet_pkg::block_width / DIN_DOUT_WIDTH;
    localparam int cnt_width = $clog2(words);

    friet_pkg::block_t shift;
    logic [cnt_width-1:0] cnt;
    logic busy;
    logic block_last;
    logic word_xfer;
    logic final_word;
    logic block_take;

    assign final_word = (cnt == cnt_width'(words - 1));
    assign word_xfer = busy & buf_dout_ready;

    // Next block may enter as the final word leaves
    assign out_block_ready = ~busy | (word_xfer & final_word);
    assign block_take = out_block_valid & out_block_ready;

    assign buf_dout = shift[friet_pkg::block_width-1 -: DIN_DOUT_WIDTH];
    assign buf_dout_valid = busy;
    assign buf_dout_last = block_last & final_word;

    always_ff @(posedge clk) begin
        if (reg_compare_tag_rst) begin
            busy <= 1'b0;
            cnt <= '0;
            block_last <= 1'b0;
        end else if (block_take) begin
            busy <= 1'b1;
            cnt <= '0;
            block_last <= out_block_last;
        end else if (word_xfer) begin
            cnt <= cnt + 1'b1;
            if (final_word) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (block_take) begin
            shift <= out_block;
        end else if (word_xfer) begin
            shift <= shift << DIN_DOUT_WIDTH;
        end
    end

endmodule

`default_nettype wire

/* source/stream_controller.sv */
//--------------------------------------------------------------------------
// Controller: instruction register, phase FSM, input gating, core
// operation select and the tag verify and verdict selects
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stream_controller #(
    parameter int DIN_DOUT_WIDTH = 32
) (
    input  wire                    clk,
    input  wire                    reg_compare_tag_rst,
    input  wire friet_pkg::inst_t  inst,
    input  wire                    inst_valid,
    output logic                   inst_ready,
    input  wire                    din_valid,
    input  wire                    din_ready_int,
    output logic                   din_ready,
    output logic                   in_enable,
    input  wire                    in_block_valid,
    input  wire                    in_block_ready,
    input  wire                    in_block_last,
    output friet_pkg::core_oper_t  core_oper,
    output logic                   core_start,
    output logic                   verify_mode,
    output logic                   clear_compare,
    output logic                   verdict_select,
    input  wire                    dout_valid,
    input  wire                    dout_ready,
    input  wire                    dout_last
);

    typedef enum logic [2:0] {
        ph_idle, ph_stream, ph_squeeze, ph_verify, ph_verdict
    } phase_t;

    phase_t phase;
    friet_pkg::inst_t reg_inst;
    logic started;
    logic input_done;
    logic input_open;
    logic block_xfer;
    logic dout_end;

    assign block_xfer = in_block_valid & in_block_ready;
    assign dout_end = dout_valid & dout_ready & dout_last;

    // Input closes once the last message block has entered the core
    assign input_open = ((phase == ph_stream) & ~input_done) | (phase == ph_verify);
    assign in_enable = din_valid & input_open;
    assign din_ready = din_ready_int & input_open;

    assign inst_ready = (phase == ph_idle);
    assign core_start = ((phase == ph_squeeze) | (phase == ph_verify)) & ~started;
    assign clear_compare = (phase == ph_verify) & ~started;
    assign verify_mode = (phase == ph_verify);
    assign verdict_select = (phase == ph_verdict);

    always_comb begin
        case (reg_inst)
            friet_pkg::inst_load_key: core_oper = friet_pkg::core_load;
            friet_pkg::inst_encrypt:  core_oper = friet_pkg::core_encrypt;
            friet_pkg::inst_decrypt:  core_oper = friet_pkg::core_decrypt;
            default:                  core_oper = friet_pkg::core_squeeze;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_compare_tag_rst) begin
            phase <= ph_idle;
            reg_inst <= friet_pkg::inst_load_key;
            started <= 1'b0;
            input_done <= 1'b0;
        end else begin
            case (phase)
                ph_idle: begin
                    started <= 1'b0;
                    input_done <= 1'b0;
                    if (inst_valid) begin
                        reg_inst <= inst;
                        case (inst)
                            friet_pkg::inst_load_key,
                            friet_pkg::inst_encrypt,
                            friet_pkg::inst_decrypt: phase <= ph_stream;
                            friet_pkg::inst_tag:     phase <= ph_squeeze;
                            friet_pkg::inst_verify:  phase <= ph_verify;
                            // Unknown codes are dropped
                            default:                 phase <= ph_idle;
                        endcase
                    end
                end
                ph_stream: begin
                    if (block_xfer && in_block_last) begin
                        input_done <= 1'b1;
                    end
                    // Key load has no output, so it ends at the core
                    if (reg_inst == friet_pkg::inst_load_key) begin
                        if (block_xfer && in_block_last) begin
                            phase <= ph_idle;
                        end
                    end else if (dout_end) begin
                        phase <= ph_idle;
                    end
                end
                ph_squeeze: begin
                    started <= 1'b1;
                    if (dout_end) begin
                        phase <= ph_idle;
                    end
                end
                ph_verify: begin
                    started <= 1'b1;
                    if (block_xfer) begin
                        phase <= ph_verdict;
                    end
                end
                ph_verdict: begin
                    if (dout_valid && dout_ready) begin
                        phase <= ph_idle;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/tag_verify.sv */
//--------------------------------------------------------------------------
// Tag verification: sticky difference between squeezed state and tag
// block, and the dout multiplexer carrying the verdict word
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tag_verify #(
    parameter int DIN_DOUT_WIDTH = 32
) (
    input  wire                       clk,
    input  wire                       reg_compare_tag_rst,
    input  wire                       clear_compare,
    input  wire                       verify_mode,
    input  wire                       verdict_select,
    input  wire friet_pkg::block_t    out_block,
    input  wire                       out_block_valid,
    input  wire friet_pkg::block_t    in_block,
    input  wire                       in_block_valid,
    input  wire [DIN_DOUT_WIDTH-1:0]  buf_dout,
    input  wire                       buf_dout_last,
    input  wire                       buf_dout_valid,
    output logic                      buf_dout_ready,
    output logic [DIN_DOUT_WIDTH-1:0] dout,
    output logic                      dout_last,
    output logic                      dout_valid,
    input  wire                       dout_ready
);

    friet_pkg::block_t compare_tag;
    logic [DIN_DOUT_WIDTH-1:0] verdict_word;

    // Any differing bit stays set until the next verify
    always_ff @(posedge clk) begin
        if (reg_compare_tag_rst || clear_compare) begin
            compare_tag <= '0;
        end else if (verify_mode && out_block_valid && in_block_valid) begin
            compare_tag <= compare_tag | (out_block ^ in_block);
        end
    end

    // Bit 0 flags a failed tag
    assign verdict_word = {{(DIN_DOUT_WIDTH-4){1'b0}}, friet_pkg::verdict_fixed_bits,
                           |compare_tag};

    always_comb begin
        if (verdict_select) begin
            dout = verdict_word;
            dout_last = 1'b1;
            dout_valid = 1'b1;
            buf_dout_ready = 1'b0;
        end else begin
            dout = buf_dout;
            dout_last = buf_dout_last;
            dout_valid = buf_dout_valid;
            buf_dout_ready = dout_ready;
        end
    end

endmodule

`default_nettype wire

/* tb/friet_stream_vectors.svh */
//--------------------------------------------------------------------------
// Stimulus table of the stream engine testbench: instruction per step,
// input blocks and expected output words
//--------------------------------------------------------------------------

// Columns: instruction, input block count, output word count, then two
// input blocks and two expected blocks per step, words taken from the top
localparam int num_steps = 7;

friet_pkg::inst_t step_inst [0:num_steps-1] = '{
    friet_pkg::inst_load_key, friet_pkg::inst_encrypt, friet_pkg::inst_tag,
    friet_pkg::inst_verify, friet_pkg::inst_verify, friet_pkg::inst_load_key,
    friet_pkg::inst_decrypt
};

int step_in_count [0:num_steps-1] = '{1, 2, 0, 1, 1, 1, 2};
int step_out_count [0:num_steps-1] = '{0, 8, 4, 1, 1, 0, 8};

// Key, plaintext, good tag, tag with bit 0 flipped, key, ciphertext
friet_pkg::block_t step_in [0:2*num_steps-1] = '{
    128'h11110000_22220000_33330000_44440000, 128'h0,
    128'h0000a1a1_0000b1b1_0000c1c1_0000d1d1, 128'h05050000_06060000_07070000_08080000,
    128'h0, 128'h0,
    128'h3535c1c1_4343d1d1_1919a1a1_2727b1b1, 128'h0,
    128'h3535c1c1_4343d1d1_1919a1a1_2727b1b0, 128'h0,
    128'h11110000_22220000_33330000_44440000, 128'h0,
    128'h1111a1a1_2222b1b1_3333c1c1_4444d1d1, 128'h2727b1b1_3535c1c1_4343d1d1_1919a1a1
};

// Ciphertext, tag, verdict pass, verdict fail, recovered plaintext
friet_pkg::block_t step_out [0:2*num_steps-1] = '{
    128'h0, 128'h0,
    128'h1111a1a1_2222b1b1_3333c1c1_4444d1d1, 128'h2727b1b1_3535c1c1_4343d1d1_1919a1a1,
    128'h3535c1c1_4343d1d1_1919a1a1_2727b1b1, 128'h0,
    128'h0000000e_00000000_00000000_00000000, 128'h0,
    128'h0000000f_00000000_00000000_00000000, 128'h0,
    128'h0, 128'h0,
    128'h0000a1a1_0000b1b1_0000c1c1_0000d1d1, 128'h05050000_06060000_07070000_08080000
};

/* tb/friet_stream_tb.sv */
//--------------------------------------------------------------------------
// Testbench of the stream engine: clock and reset, reference model,
// compare tasks, instruction, din and dout drivers and the table loop
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module friet_stream_tb;

    localparam int DIN_DOUT_WIDTH = 32;
    localparam int bw = friet_pkg::block_width;
    localparam int words = bw / DIN_DOUT_WIDTH;
    localparam int timeout_cycles = 200;

    logic clk = 1'b0;
    logic reg_compare_tag_rst;
    friet_pkg::inst_t inst;
    logic inst_valid;
    logic inst_ready;
    logic [DIN_DOUT_WIDTH-1:0] din;
    logic din_last;
    logic din_valid;
    logic din_ready;
    logic [DIN_DOUT_WIDTH-1:0] dout;
    logic dout_last;
    logic dout_valid;
    logic dout_ready;

    friet_pkg::block_t model_state;
    logic [DIN_DOUT_WIDTH-1:0] model_words [$];

    `include "friet_stream_vectors.svh"

    friet_stream_top #(.DIN_DOUT_WIDTH(DIN_DOUT_WIDTH)) UUT (
        .clk(clk), .reg_compare_tag_rst(reg_compare_tag_rst),
        .inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready),
        .din(din), .din_last(din_last), .din_valid(din_valid), .din_ready(din_ready),
        .dout(dout), .dout_last(dout_last), .dout_valid(dout_valid),
        .dout_ready(dout_ready)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DIN_DOUT_WIDTH-1:0] got,
                              input logic [DIN_DOUT_WIDTH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    // Word k of a block, most significant first
    function automatic logic [DIN_DOUT_WIDTH-1:0] word_of(input friet_pkg::block_t b,
                                                          input int k);
        return b[bw-1-k*DIN_DOUT_WIDTH -: DIN_DOUT_WIDTH];
    endfunction

    function automatic friet_pkg::block_t rotate_lane(input friet_pkg::block_t x);
        return (x << friet_pkg::lane_width) | (x >> (bw - friet_pkg::lane_width));
    endfunction

    function automatic void push_block(input friet_pkg::block_t b);
        int k;
        for (k = 0; k < words; k++) begin
            model_words.push_back(word_of(b, k));
        end
    endfunction

    // Reference model of the duplex rules
    task automatic predict_outputs(input int s);
        friet_pkg::block_t b;
        friet_pkg::block_t r;
        int k;
        model_words.delete();
        case (step_inst[s])
            friet_pkg::inst_load_key: model_state = step_in[2*s];
            friet_pkg::inst_encrypt, friet_pkg::inst_decrypt: begin
                for (k = 0; k < step_in_count[s]; k++) begin
                    b = step_in[2*s+k];
                    r = model_state ^ b;
                    push_block(r);
                    // Ciphertext feeds the next state in both directions
                    if (step_inst[s] == friet_pkg::inst_encrypt) begin
                        model_state = rotate_lane(r);
                    end else begin
                        model_state = rotate_lane(b);
                    end
                end
            end
            friet_pkg::inst_tag: push_block(model_state);
            friet_pkg::inst_verify: begin
                r = model_state ^ step_in[2*s];
                model_words.push_back({{(DIN_DOUT_WIDTH-4){1'b0}},
                                       friet_pkg::verdict_fixed_bits, |r});
            end
            default: abort_run($sformatf("Step %0d holds an unknown instruction", s));
        endcase
    endtask

    task automatic check_table(input int s);
        int n;
        if (model_words.size() != step_out_count[s]) begin
            abort_run($sformatf("Step %0d lists %0d output words but the model gives %0d",
                                s, step_out_count[s], model_words.size()));
        end
        for (n = 0; n < step_out_count[s]; n++) begin
            if (word_of(step_out[2*s + n/words], n % words) !== model_words[n]) begin
                abort_run($sformatf("Step %0d word %0d of the table disagrees with the model",
                                    s, n));
            end
        end
    endtask

    // Idle means no stray output word either
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!inst_ready) begin
            check_flag("dout_valid", dout_valid, 1'b0);
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("Timeout while waiting for the DUT to return to idle");
            end
            @(negedge clk);
        end
        check_flag("dout_valid", dout_valid, 1'b0);
        @(posedge clk);
        #0.5;
    endtask

    task automatic send_instruction(input friet_pkg::inst_t code);
        inst = code;
        inst_valid = 1'b1;
        @(posedge clk);
        #0.5;
        inst_valid = 1'b0;
        // Accepted code leaves the idle phase
        check_flag("inst_ready", inst_ready, 1'b0);
    endtask

    task automatic send_words(input int s, input bit stalls);
        int n;
        int total;
        int idle;
        logic xfer;
        total = step_in_count[s] * words;
        n = 0;
        idle = 0;
        while (n < total) begin
            din = word_of(step_in[2*s + n/words], n % words);
            din_last = (n == total - 1);
            // Gaps only between words, valid holds until taken
            if (!din_valid) begin
                din_valid = !stalls || ($urandom % 3 != 0);
            end
            @(negedge clk);
            xfer = din_valid && din_ready;
            @(posedge clk);
            #0.5;
            if (xfer) begin
                n++;
                idle = 0;
                din_valid = 1'b0;
            end else begin
                idle++;
                if (idle > timeout_cycles) begin
                    abort_run($sformatf("Timeout while sending word %0d of step %0d", n, s));
                end
            end
        end
        din_valid = 1'b0;
        din_last = 1'b0;
    endtask

    task automatic collect_words(input int s, input bit stalls);
        int n;
        int idle;
        n = 0;
        idle = 0;
        while (n < step_out_count[s]) begin
            dout_ready = !stalls || ($urandom % 3 != 0);
            @(negedge clk);
            if (dout_valid && dout_ready) begin
                check_word("dout", dout, word_of(step_out[2*s + n/words], n % words));
                check_flag("dout_last", dout_last, n == step_out_count[s] - 1);
                n++;
                idle = 0;
            end else begin
                idle++;
                if (idle > timeout_cycles) begin
                    abort_run($sformatf("Timeout while waiting for word %0d of step %0d", n, s));
                end
            end
            @(posedge clk);
            #0.5;
        end
        dout_ready = 1'b0;
    endtask

    initial begin
        int seed;
        int rnd;
        int pass;
        int s;
        seed = 83835;
        rnd = $urandom(seed);
        reg_compare_tag_rst = 1'b1;
        inst = friet_pkg::inst_load_key;
        inst_valid = 1'b0;
        din = '0;
        din_last = 1'b0;
        din_valid = 1'b0;
        dout_ready = 1'b0;
        model_state = '0;
        repeat (10) @(posedge clk);
        #0.5;
        reg_compare_tag_rst = 1'b0;

        @(negedge clk);
        check_flag("inst_ready", inst_ready, 1'b1);
        check_flag("dout_valid", dout_valid, 1'b0);
        check_flag("din_ready", din_ready, 1'b0);
        @(posedge clk);
        #0.5;

        // Second pass repeats the table under random back-pressure
        for (pass = 0; pass < 2; pass++) begin
            for (s = 0; s < num_steps; s++) begin
                predict_outputs(s);
                check_table(s);
                wait_idle();
                send_instruction(step_inst[s]);
                fork
                    send_words(s, pass == 1);
                    collect_words(s, pass == 1);
                join
            end
        end
        wait_idle();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
